//--- common/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Serial link timing

// Clock cycles per serial bit
// 8 for simulation, 434 for 50 MHz at 115200 baud
`define UART_CLKS_PER_BIT 8

// Start bit, 8 data bits and stop bit
`define UART_FRAME_BITS 10

// Message table limits

// Longest JSON line in bytes including the newline
`define MSG_MAX_LEN 27

`endif

//--- common/motorCmdPkg.sv
package motorCmdPkg;

    // Motor drive command codes
    typedef enum logic [2:0] {
        cmdStop      = 3'd0,
        cmdLeft      = 3'd1,
        cmdRight     = 3'd2,
        cmdFwdSlow   = 3'd3,
        cmdFwdMedium = 3'd4,
        cmdFwdFast   = 3'd5
    } cmdCode_t;                                 // Codes 6 and 7 fall back to stop

    typedef logic [7:0] byteData_t;              // One ASCII character
    typedef logic [4:0] msgIndex_t;              // Byte position, up to 31

    // Message sequencer FSM
    typedef enum logic [1:0] {
        seqIdle,                                 // Waiting for start
        seqLoad,                                 // Hand byte to transmitter
        seqWait,                                 // Frame in flight
        seqFinish                                // Done pulse
    } seqState_t;

    // One table entry
    typedef struct packed {
        byteData_t dataByte;                     // Character to send
        logic      last;                         // Set on the closing newline
    } romWord_t;

endpackage

//--- uartTx/baudTimer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module baudTimer (
    input  logic clk,
    input  logic rst,
    input  logic frameActive,
    output logic bitTick,
    output logic frameEnd
);

    localparam int clkCountWidth = $clog2(`UART_CLKS_PER_BIT);
    localparam int bitCountWidth = $clog2(`UART_FRAME_BITS);

    logic [clkCountWidth-1:0] clkCount;                  // Cycles within a bit
    logic [bitCountWidth-1:0] bitCount;                  // Bits within a frame

    assign bitTick  = frameActive && (clkCount == clkCountWidth'(`UART_CLKS_PER_BIT - 1));
    assign frameEnd = bitTick && (bitCount == bitCountWidth'(`UART_FRAME_BITS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clkCount <= '0;
            bitCount <= '0;
        end else if (!frameActive) begin
            clkCount <= '0;                              // Hold cleared between frames
            bitCount <= '0;
        end else if (bitTick) begin
            clkCount <= '0;
            bitCount <= frameEnd ? '0 : bitCount + 1'b1; // Wrap after stop bit
        end else begin
            clkCount <= clkCount + 1'b1;
        end
    end

endmodule

//--- uartTx/uartTransmitter.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uartTransmitter import motorCmdPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      byteStrobe,
    input  byteData_t txByte,
    output logic      txd,
    output logic      txIdle
);

    logic                        frameActive;            // Frame on the line
    logic                        bitTick;                // End of a bit period
    logic                        frameEnd;               // End of the stop bit
    logic [`UART_FRAME_BITS-1:0] shiftReg;               // Stop, data, start from MSB down

    baudTimer i_baudTimer (
        .clk        (clk),
        .rst        (rst),
        .frameActive(frameActive),
        .bitTick    (bitTick),
        .frameEnd   (frameEnd)
    );

    assign txd    = shiftReg[0];                         // Line follows the low bit
    assign txIdle = !frameActive;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shiftReg    <= '1;                           // Line idles high
            frameActive <= 1'b0;
        end else if (byteStrobe && !frameActive) begin
            shiftReg    <= {1'b1, txByte, 1'b0};         // Start bit goes out first
            frameActive <= 1'b1;
        end else if (frameEnd) begin
            shiftReg    <= '1;                           // Back to mark level
            frameActive <= 1'b0;
        end else if (bitTick) begin
            shiftReg    <= {1'b1, shiftReg[`UART_FRAME_BITS-1:1]}; // LSB first
        end
    end

endmodule

//--- verilog/commandRom.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module commandRom import motorCmdPkg::*; (
    input  cmdCode_t  command,
    input  msgIndex_t index,
    output romWord_t  romWord
);

    localparam int textBits = 8 * `MSG_MAX_LEN;       // Widest message
    localparam byteData_t newLine = 8'h0A;

    typedef logic [textBits-1:0] msgText_t;

    // Texts are right aligned so the newline sits in the low byte
    localparam msgText_t textStop      = "{\"T\":1,\"L\":0,\"R\":0}\n";
    localparam msgText_t textLeft      = "{\"T\":1,\"L\":-0.00,\"R\":0.12}\n";
    localparam msgText_t textRight     = "{\"T\":1,\"L\":0.12,\"R\":-0.12}\n";
    localparam msgText_t textFwdSlow   = "{\"T\":1,\"L\":0.05,\"R\":0.05}\n";
    localparam msgText_t textFwdMedium = "{\"T\":1,\"L\":0.25,\"R\":0.25}\n";
    localparam msgText_t textFwdFast   = "{\"T\":1,\"L\":0.5,\"R\":0.5}\n";

    // Byte counts including the newline
    localparam msgIndex_t lenStop      = 5'd20;
    localparam msgIndex_t lenLeft      = 5'd27;
    localparam msgIndex_t lenRight     = 5'd27;
    localparam msgIndex_t lenFwdSlow   = 5'd26;
    localparam msgIndex_t lenFwdMedium = 5'd26;
    localparam msgIndex_t lenFwdFast   = 5'd24;

    msgText_t  selText;                                  // Text of current command
    msgIndex_t selLen;                                   // Its length

    // Pick one character, first character at index 0
    function automatic romWord_t pickChar(
        input msgText_t  text,
        input msgIndex_t len,
        input msgIndex_t idx
    );
        romWord_t  word;
        msgIndex_t pos;
        pos = len - idx - 5'd1;                          // Byte slot from the low end
        if (idx < len) begin
            word.dataByte = text[int'(pos) * 8 +: 8];
        end else begin
            word.dataByte = newLine;                     // Past the end stays on newline
        end
        word.last = (word.dataByte == newLine);          // Only newline ends a message
        return word;
    endfunction

    // Text select by command
    always_comb begin
        case (command)
            cmdLeft: begin
                selText = textLeft;
                selLen  = lenLeft;
            end
            cmdRight: begin
                selText = textRight;
                selLen  = lenRight;
            end
            cmdFwdSlow: begin
                selText = textFwdSlow;
                selLen  = lenFwdSlow;
            end
            cmdFwdMedium: begin
                selText = textFwdMedium;
                selLen  = lenFwdMedium;
            end
            cmdFwdFast: begin
                selText = textFwdFast;
                selLen  = lenFwdFast;
            end
            default: begin                               // Stop, also codes 6 and 7
                selText = textStop;
                selLen  = lenStop;
            end
        endcase
    end

    assign romWord = pickChar(selText, selLen, index);   // Same cycle answer

endmodule

//--- verilog/messageSequencer.sv
`timescale 1ns/1ps

module messageSequencer import motorCmdPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  cmdCode_t  command,
    input  romWord_t  romWord,
    input  logic      txIdle,
    output cmdCode_t  romCommand,
    output msgIndex_t romIndex,
    output logic      byteStrobe,
    output byteData_t txByte,
    output logic      busy,
    output logic      done
);

    seqState_t state;
    logic      lastSent;                                 // Byte in flight closes the message
    logic      accept;                                   // Start taken this cycle
    logic      frameDone;                                // Transmitter back to idle

    assign accept = start && ((state == seqIdle) || (state == seqFinish));

    // Strobe still high means txIdle has not dropped yet
    assign frameDone = txIdle && !byteStrobe;

    assign busy = (state == seqLoad) || (state == seqWait);
    assign done = (state == seqFinish);                  // One cycle only

    // Control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= seqIdle;
            romIndex   <= '0;
            byteStrobe <= 1'b0;
            lastSent   <= 1'b0;
        end else begin
            byteStrobe <= 1'b0;                          // Pulse by default
            case (state)
                seqIdle, seqFinish: begin
                    if (accept) begin
                        romIndex <= '0;                  // First character
                        state    <= seqLoad;
                    end else begin
                        state    <= seqIdle;
                    end
                end
                seqLoad: begin
                    byteStrobe <= 1'b1;                  // Transmitter is idle here
                    lastSent   <= romWord.last;
                    state      <= seqWait;
                end
                seqWait: begin
                    if (frameDone) begin
                        if (lastSent) begin
                            state <= seqFinish;
                        end else begin
                            romIndex <= romIndex + 5'd1; // Next character
                            state    <= seqLoad;
                        end
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (accept) begin
            romCommand <= command;                       // Held for the whole message
        end
        if (state == seqLoad) begin
            txByte <= romWord.dataByte;                  // Travels with byteStrobe
        end
    end

endmodule

//--- verilog/jsonUartTop.sv
`timescale 1ns/1ps

module jsonUartTop import motorCmdPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  cmdCode_t command,
    output logic     txd,
    output logic     busy,
    output logic     done
);

    cmdCode_t  romCommand;                               // Latched code to the table
    msgIndex_t romIndex;                                 // Current byte position
    romWord_t  romWord;                                  // Character and last flag
    logic      byteStrobe;                               // Byte handoff pulse
    byteData_t txByte;
    logic      txIdle;

    messageSequencer i_messageSequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .command   (command),
        .romWord   (romWord),
        .txIdle    (txIdle),
        .romCommand(romCommand),
        .romIndex  (romIndex),
        .byteStrobe(byteStrobe),
        .txByte    (txByte),
        .busy      (busy),
        .done      (done)
    );

    commandRom i_commandRom (
        .command(romCommand),
        .index  (romIndex),
        .romWord(romWord)
    );

    uartTransmitter i_uartTransmitter (
        .clk       (clk),
        .rst       (rst),
        .byteStrobe(byteStrobe),
        .txByte    (txByte),
        .txd       (txd),
        .txIdle    (txIdle)
    );

endmodule

//--- testbench/uartMonitor.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uartMonitor import motorCmdPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      txd,
    output byteData_t rxByte,
    output logic      rxValid,
    output logic      frameError
);

    byteData_t shiftIn;                                  // Data bits as they arrive
    logic      aborted = 1'b0;                           // Reset hit the current frame
    logic      startOk;
    logic      stopOk;
    int        bitIdx;

    initial begin
        rxByte     = '0;
        rxValid    = 1'b0;
        frameError = 1'b0;
    end

    always @(posedge rst) aborted = 1'b1;                // Cut frame is thrown away

    // Decoder, samples on falling clock so txd is settled
    initial begin
        forever begin
            @(negedge txd);                              // Leading edge of start bit
            if (!rst) begin
                aborted = 1'b0;
                repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
                startOk = !txd;
                for (bitIdx = 0; bitIdx < 8; bitIdx++) begin
                    repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                    shiftIn[bitIdx] = txd;               // LSB first
                end
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                stopOk = txd;                            // Middle of stop bit
                if (!aborted && !rst) begin
                    rxByte     = shiftIn;
                    frameError = !(startOk && stopOk);
                    rxValid    = 1'b1;                   // Held across one rising edge
                    @(negedge clk);
                    rxValid    = 1'b0;
                    frameError = 1'b0;
                end
            end
        end
    end

endmodule

//--- testbench/tbJsonUart.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tbJsonUart import motorCmdPkg::*; ();

    localparam int clkPeriod  = 40;
    localparam int msgCount   = 21;                      // 8 ordered, 10 random, 3 special
    localparam int byteCycles = `UART_FRAME_BITS * `UART_CLKS_PER_BIT + 4;
    localparam int timeoutCycles = msgCount * `MSG_MAX_LEN * byteCycles + msgCount * 200 + 2000;

    logic      clk = 1'b0;
    logic      rst;
    logic      start;
    cmdCode_t  command;
    logic      txd;
    logic      busy;
    logic      done;
    byteData_t rxByte;
    logic      rxValid;
    logic      frameError;

    byteData_t expQ[$];                                  // Bytes still owed by the DUT
    byteData_t expByte;
    int        errorCount   = 0;
    int        byteCount    = 0;
    int        doneCount    = 0;
    int        expectedDone = 0;
    int        seed         = 6719;
    string     testName     = "reset";

    always #(clkPeriod / 2) clk = ~clk;

    jsonUartTop i_jsonUartTop (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .command(command),
        .txd    (txd),
        .busy   (busy),
        .done   (done)
    );

    uartMonitor i_uartMonitor (
        .clk       (clk),
        .rst       (rst),
        .txd       (txd),
        .rxByte    (rxByte),
        .rxValid   (rxValid),
        .frameError(frameError)
    );

    task automatic checkValue(input string what, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            errorCount++;
            $display("ERROR %s %s: expected %0h, actual %0h", testName, what, expVal, actVal);
        end
    endtask

    // Received bytes against the head of the queue
    always @(posedge clk) begin
        if (rxValid) begin
            byteCount++;
            assert (!frameError) else begin
                errorCount++;
                $display("ERROR %s: framing fault on received byte", testName);
            end
            if (expQ.size() == 0) begin
                errorCount++;
                $display("ERROR %s: byte %0h arrived with none expected", testName, rxByte);
            end else begin
                expByte = expQ.pop_front();
                checkValue("byte", expByte, rxByte);
            end
        end
    end

    always @(posedge clk) begin
        if (done === 1'b1) begin
            doneCount++;
        end
    end

    // Reference texts
    function automatic string messageText(input int code);
        case (code)
            1: return "{\"T\":1,\"L\":-0.00,\"R\":0.12}\n";
            2: return "{\"T\":1,\"L\":0.12,\"R\":-0.12}\n";
            3: return "{\"T\":1,\"L\":0.05,\"R\":0.05}\n";
            4: return "{\"T\":1,\"L\":0.25,\"R\":0.25}\n";
            5: return "{\"T\":1,\"L\":0.5,\"R\":0.5}\n";
            default: return "{\"T\":1,\"L\":0,\"R\":0}\n"; // Stop and codes 6 and 7
        endcase
    endfunction

    task automatic stepToDrive;
        @(posedge clk);
        #5;
    endtask

    task automatic queueMessage(input int code);
        string text;
        int    k;
        text = messageText(code);
        for (k = 0; k < text.len(); k++) begin
            expQ.push_back(text[k]);
        end
    endtask

    task automatic issueStart(input int code);
        logic [2:0] bits;
        bits = code;
        stepToDrive();
        command = cmdCode_t'(bits);
        start   = 1'b1;
        stepToDrive();
        start   = 1'b0;                                  // One-cycle strobe
    endtask

    // Busy holds until done and done lasts one cycle
    task automatic waitForDone;
        while (done !== 1'b1) begin
            @(negedge clk);
            if (done !== 1'b1) begin
                checkValue("busy", 1, busy);
            end
        end
        expectedDone++;
        checkValue("bytes left at done", 0, expQ.size());
        checkValue("busy at done", 0, busy);
        @(negedge clk);
        checkValue("done width", 0, done);
        checkValue("done pulses", expectedDone, doneCount);
    endtask

    task automatic runMessage(input int code, input string name);
        testName = name;
        queueMessage(code);
        issueStart(code);
        waitForDone();
    endtask

    initial begin
        int code;
        int i;
        rst     = 1'b1;
        start   = 1'b0;
        command = cmdStop;
        repeat (16) @(posedge clk);
        #5 rst = 1'b0;
        testName = "idle line";
        repeat (20) begin
            @(negedge clk);
            checkValue("txd", 1, txd);                   // Mark level before first start
        end
        for (code = 0; code < 8; code++) begin
            runMessage(code, $sformatf("code %0d", code));
        end
        for (i = 0; i < 10; i++) begin
            code = $random(seed) & 7;
            runMessage(code, $sformatf("random %0d code %0d", i, code));
        end
        testName = "dropped strobe";
        queueMessage(cmdFwdFast);
        issueStart(cmdFwdFast);
        repeat (100) @(negedge clk);
        checkValue("busy", 1, busy);
        issueStart(cmdLeft);                             // Should be ignored
        waitForDone();
        repeat (200) begin
            @(negedge clk);
            checkValue("txd after drop", 1, txd);
        end
        testName = "reset mid-message";
        queueMessage(cmdRight);
        issueStart(cmdRight);
        repeat (600) @(posedge clk);                     // Several bytes into the line
        #5 rst = 1'b1;
        #1;
        checkValue("txd", 1, txd);
        checkValue("busy", 0, busy);
        checkValue("done", 0, done);
        expQ.delete();
        repeat (4) @(posedge clk);
        #5 rst = 1'b0;
        repeat (100) @(posedge clk);                     // Monitor drops the cut frame
        runMessage(cmdFwdMedium, "after reset");
        repeat (20) @(negedge clk);
        testName = "closing";
        checkValue("done pulses", expectedDone, doneCount);
        $display("Bytes received %0d, done pulses %0d of %0d, errors %0d",
                 byteCount, doneCount, expectedDone, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the DUT did not finish all messages in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/motorCmdPkg.sv
uartTx/baudTimer.sv
uartTx/uartTransmitter.sv
verilog/commandRom.sv
verilog/messageSequencer.sv
verilog/jsonUartTop.sv
testbench/uartMonitor.sv
testbench/tbJsonUart.sv
